// File: rtl/pll_defines.svh
`ifndef PLL_DEFINES_SVH
`define PLL_DEFINES_SVH

//##########################################################################
// pll clock block sizing
//##########################################################################

`define PLL_NOUT         2     // output clocks

// divider field widths
`define PLL_DIVINW       8     // reference divider
`define PLL_DIVFBW       8     // feedback divider
`define PLL_DIVFRACW     8     // fractional feedback divider
`define PLL_DIVOUTW      8     // per output divider

//##########################################################################
// sequencing and measurement
//##########################################################################

`define PLL_LOCK_CYCLES  32    // ref cycles from en to freqlock
`define PLL_RST_CYCLES   8     // pll reset hold
`define PLL_LOCK_TIMEOUT 256   // lock wait before fault

`define FM_WINDOW        1024  // meter gate in ref cycles
`define FM_CNTW          12    // meter count width

`endif

// File: rtl/wb_pkg.sv
package wb_pkg;

   //#######################################################################
   // wishbone classic single transfer
   //#######################################################################

   typedef logic [3:0]  wb_adr_t;   // word address
   typedef logic [31:0] wb_dat_t;   // data word
   typedef logic [3:0]  wb_sel_t;   // byte lanes

   // master to slave
   typedef struct packed {
      logic    cyc;   // bus cycle in progress
      logic    stb;   // transfer strobe
      logic    we;    // write when high
      wb_adr_t adr;   // register index
      wb_dat_t dat;   // write data
      wb_sel_t sel;   // byte enables
   } wb_req_t;

   // slave to master
   typedef struct packed {
      logic    ack;   // one cycle per transfer
      wb_dat_t dat;   // read data, valid with ack
   } wb_rsp_t;

endpackage

// File: rtl/pll_pkg.sv
package pll_pkg;

`include "pll_defines.svh"

   typedef logic [`PLL_DIVOUTW-1:0] divout_t;   // one output divider

   // divider settings, regs to pll model
   typedef struct packed {
      logic [`PLL_DIVINW-1:0]   divin;     // stored only
      logic [`PLL_DIVFBW-1:0]   divfb;     // stored only
      logic [`PLL_DIVFRACW-1:0] divfrac;   // stored only
      divout_t [`PLL_NOUT-1:0]  divout;    // per output
   } pll_cfg_t;

   // software controls, CTRL register layout from bit 0 up
   typedef struct packed {
      logic                 meter_sel;   // bit 4
      logic [`PLL_NOUT-1:0] clken;       // bits 3:2
      logic                 bypass;      // bit 1
      logic                 start;       // bit 0
   } pll_ctrl_t;

   typedef enum logic [2:0] {
      OFF, RST, WAIT_LOCK, RUN, FAULT
   } seq_state_e;

   typedef struct packed {
      seq_state_e state;       // bits 5:3
      logic       freqlock;    // bit 2
      logic       phaselock;   // bit 1
      logic       fault;       // bit 0
   } pll_status_t;

   //#######################################################################
   // register data views
   //#######################################################################

   typedef struct packed {
      logic [31-`PLL_DIVINW-`PLL_DIVFBW-`PLL_DIVFRACW:0] rsvd;
      logic [`PLL_DIVINW-1:0]   divin;     // bits 23:16
      logic [`PLL_DIVFBW-1:0]   divfb;     // bits 15:8
      logic [`PLL_DIVFRACW-1:0] divfrac;   // bits 7:0
   } div_word_t;

   typedef struct packed {
      logic [31-`PLL_NOUT*`PLL_DIVOUTW:0] rsvd;
      divout_t [`PLL_NOUT-1:0]          divout;   // out0 in low byte
   } out_word_t;

   // same 32 bit word, decoded by address
   typedef union packed {
      div_word_t   div;   // at DIV
      out_word_t   out;   // at OUT
      logic [31:0] raw;   // everything else
   } reg_word_u;

   // word addresses
   localparam logic [3:0] CTRL   = 4'd0;
   localparam logic [3:0] DIV    = 4'd1;
   localparam logic [3:0] OUT    = 4'd2;
   localparam logic [3:0] STATUS = 4'd3;
   localparam logic [3:0] FREQ   = 4'd4;

endpackage

// File: rtl/pll_model.sv
`timescale 1ns/100ps
`include "pll_defines.svh"

module pll_model import pll_pkg::*; (
   input  logic                 clk,         // reference clock
   input  logic                 pll_reset,   // active high async
   input  logic                 en,          // pll enable
   input  logic                 bypass,      // ref straight to outputs
   input  logic [`PLL_NOUT-1:0] clken,       // per output gate
   input  pll_cfg_t             cfg,         // divider settings
   output logic [`PLL_NOUT-1:0] clkout,      // divided outputs
   output logic                 clkvco,      // vco, n/m = 1
   output logic                 freqlock,
   output logic                 phaselock
);

   localparam int LOCKW = $clog2(`PLL_LOCK_CYCLES + 1);

   logic [LOCKW-1:0] lock_cnt;   // cycles of en so far

   assign clkvco = clk & en & ~pll_reset;   // vco tracks ref

   //########################################################################
   // lock model
   //########################################################################

   always_ff @(posedge clk or posedge pll_reset) begin
      if (pll_reset) begin
         lock_cnt  <= '0;
         freqlock  <= 1'b0;
         phaselock <= 1'b0;
      end else if (!en) begin   // disabled, lock lost
         lock_cnt  <= '0;
         freqlock  <= 1'b0;
         phaselock <= 1'b0;
      end else begin
         if (lock_cnt != LOCKW'(`PLL_LOCK_CYCLES))
            lock_cnt <= lock_cnt + 1'b1;   // saturate at lock
         freqlock  <= freqlock | (lock_cnt == LOCKW'(`PLL_LOCK_CYCLES - 1));
         phaselock <= freqlock;   // one cycle behind
      end
   end

   //########################################################################
   // output dividers
   //########################################################################

   for (genvar i = 0; i < `PLL_NOUT; i++) begin : g_out
      logic [`PLL_DIVOUTW-1:0] half;      // vco cycles per half period
      logic [`PLL_DIVOUTW-1:0] div_cnt;
      logic                    div_clk;   // divided clock
      logic                    pass;      // divout 0 or 1

      assign pass = (cfg.divout[i] < `PLL_DIVOUTW'(2));
      assign half = (cfg.divout[i] > `PLL_DIVOUTW'(3)) ? (cfg.divout[i] >> 1)
                                                       : `PLL_DIVOUTW'(1);   // min 1

      always_ff @(posedge clkvco or posedge pll_reset) begin
         if (pll_reset) begin
            div_cnt <= '0;
            div_clk <= 1'b0;
         end else if (div_cnt >= half - 1'b1) begin   // also catches a smaller divout
            div_cnt <= '0;
            div_clk <= ~div_clk;
         end else begin
            div_cnt <= div_cnt + 1'b1;
         end
      end

      // bypass takes the ref, clken gates either path
      assign clkout[i] = (bypass ? clk : (pass ? clkvco : div_clk)) & clken[i];
   end

endmodule

// File: rtl/pll_wb_regs.sv
`timescale 1ns/100ps
`include "pll_defines.svh"

module pll_wb_regs import wb_pkg::*, pll_pkg::*; (
   input  logic                clk,
   input  logic                rst_n,
   input  wb_req_t             wb_req,       // from bus master
   output wb_rsp_t             wb_rsp,       // to bus master
   output pll_cfg_t            cfg,          // divider settings
   output pll_ctrl_t           ctrl,         // start, bypass, clken, meter_sel
   output logic                cfg_change,   // pulse on DIV or OUT write
   input  pll_status_t         status,       // from sequencer
   input  logic [`FM_CNTW-1:0] freq_count,   // last meter result
   input  logic                freq_valid
);

   logic        access;    // new transfer this cycle
   logic        ack_q;
   logic [31:0] dat_q;     // read data register
   reg_word_u   rd_word;   // current content at adr
   reg_word_u   wr_word;   // content after byte merge

   // replace only the enabled byte lanes
   function automatic logic [31:0] byte_merge(
      input logic [31:0] old_w,
      input logic [31:0] new_w,
      input logic [3:0]  sel
   );
      logic [31:0] res;
      res = old_w;
      for (int b = 0; b < 4; b++) begin
         if (sel[b])
            res[8*b +: 8] = new_w[8*b +: 8];
      end
      return res;
   endfunction

   assign access = wb_req.cyc & wb_req.stb & ~ack_q;   // ack once per strobe
   assign wb_rsp = '{ack: ack_q, dat: dat_q};

   //########################################################################
   // read mux
   //########################################################################

   always_comb begin
      rd_word.raw = '0;   // unmapped reads zero
      case (wb_req.adr)
         CTRL: rd_word.raw = 32'(ctrl);
         DIV: begin
            rd_word.div.divin   = cfg.divin;
            rd_word.div.divfb   = cfg.divfb;
            rd_word.div.divfrac = cfg.divfrac;
         end
         OUT:    rd_word.out.divout = cfg.divout;
         STATUS: rd_word.raw = 32'(status);
         FREQ: begin
            rd_word.raw[16]            = freq_valid;
            rd_word.raw[`FM_CNTW-1:0]  = freq_count;
         end
         default: rd_word.raw = '0;
      endcase
   end

   assign wr_word.raw = byte_merge(rd_word.raw, wb_req.dat, wb_req.sel);

   //########################################################################
   // control and config registers
   //########################################################################

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ack_q       <= 1'b0;
         cfg_change  <= 1'b0;
         ctrl        <= '0;                 // pll off, clocks gated
         cfg.divin   <= `PLL_DIVINW'(1);    // n = 1
         cfg.divfb   <= `PLL_DIVFBW'(1);    // m = 1
         cfg.divfrac <= '0;
         cfg.divout  <= '{default: `PLL_DIVOUTW'(1)};   // vco pass through
      end else begin
         ack_q      <= access;
         cfg_change <= 1'b0;
         if (access && wb_req.we) begin
            case (wb_req.adr)
               CTRL: ctrl <= pll_ctrl_t'(wr_word.raw[$bits(pll_ctrl_t)-1:0]);
               DIV: begin
                  cfg.divin   <= wr_word.div.divin;
                  cfg.divfb   <= wr_word.div.divfb;
                  cfg.divfrac <= wr_word.div.divfrac;
                  cfg_change  <= 1'b1;   // sequencer relocks
               end
               OUT: begin
                  cfg.divout <= wr_word.out.divout;
                  cfg_change <= 1'b1;
               end
               default: ;   // read only or unmapped
            endcase
         end
      end
   end

   // read data lands with ack
   always_ff @(posedge clk) begin
      dat_q <= access ? rd_word.raw : '0;
   end

endmodule

// File: rtl/pll_sequencer.sv
`timescale 1ns/100ps
`include "pll_defines.svh"

module pll_sequencer import pll_pkg::*; (
   input  logic                 clk,
   input  logic                 rst_n,
   input  pll_ctrl_t            ctrl,         // software controls
   input  logic                 cfg_change,   // dividers rewritten
   input  logic                 freqlock,     // from pll model
   input  logic                 phaselock,
   output logic                 pll_reset,    // pll model reset, active high
   output logic                 en,           // pll enable
   output logic [`PLL_NOUT-1:0] clken,        // gated output enables
   output pll_status_t          status        // to registers
);

   localparam int CNTW = $clog2(`PLL_LOCK_TIMEOUT + 1);

   seq_state_e      state;
   seq_state_e      state_d;
   logic [CNTW-1:0] cnt;       // reset hold and lock wait
   logic            active_d;  // next state drives the pll

   //########################################################################
   // next state
   //########################################################################

   always_comb begin
      state_d = state;
      case (state)
         OFF: if (ctrl.start) state_d = RST;
         RST: begin
            if (cnt == CNTW'(`PLL_RST_CYCLES - 1))
               state_d = ctrl.bypass ? RUN : WAIT_LOCK;   // bypass skips lock
         end
         WAIT_LOCK: begin
            if (cfg_change)
               state_d = RST;
            else if (freqlock)
               state_d = RUN;
            else if (cnt == CNTW'(`PLL_LOCK_TIMEOUT - 1))
               state_d = FAULT;   // lock never came
         end
         RUN: begin
            if (cfg_change || (!ctrl.bypass && !freqlock))
               state_d = RST;     // relock
         end
         FAULT: state_d = FAULT;  // held until start drops
         default: state_d = OFF;
      endcase
      if (!ctrl.start)
         state_d = OFF;           // from anywhere
   end

   assign active_d = (state_d == WAIT_LOCK) || (state_d == RUN);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= OFF;
         cnt       <= '0;
         pll_reset <= 1'b1;   // pll held in reset
         en        <= 1'b0;
      end else begin
         state     <= state_d;
         pll_reset <= ~active_d;
         en        <= active_d;
         if (state_d != state)
            cnt <= '0;        // fresh count per state
         else if (state == RST || state == WAIT_LOCK)
            cnt <= cnt + 1'b1;
      end
   end

   assign clken  = (state == RUN) ? ctrl.clken : '0;   // open only in run
   assign status = '{state:     state,
                     freqlock:  freqlock,
                     phaselock: phaselock,
                     fault:     (state == FAULT)};

endmodule

// File: rtl/freq_meter.sv
`timescale 1ns/100ps
`include "pll_defines.svh"

module freq_meter (
   input  logic                 clk,      // reference clock
   input  logic                 rst_n,
   input  logic [`PLL_NOUT-1:0] clkout,   // clocks under test
   input  logic                 sel,      // which output
   output logic [`FM_CNTW-1:0]  count,    // edges in last window
   output logic                 valid     // first window done
);

   localparam int WINW = $clog2(`FM_WINDOW);

   logic                clk_sel;    // chosen output, async
   logic [2:0]          sync_q;     // two sync stages plus history
   logic                rise;       // rising edge seen
   logic [WINW-1:0]     win_cnt;    // position in window
   logic                win_end;
   logic [`FM_CNTW-1:0] edge_cnt;   // running count

   assign clk_sel = clkout[sel];
   assign rise    = sync_q[1] & ~sync_q[2];
   assign win_end = (win_cnt == WINW'(`FM_WINDOW - 1));

   //########################################################################
   // gate and count
   //########################################################################

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sync_q   <= '0;
         win_cnt  <= '0;
         edge_cnt <= '0;
         count    <= '0;
         valid    <= 1'b0;
      end else begin
         sync_q  <= {sync_q[1:0], clk_sel};
         win_cnt <= win_end ? '0 : win_cnt + 1'b1;
         if (win_end) begin
            count    <= edge_cnt + `FM_CNTW'(rise);   // include last cycle
            valid    <= 1'b1;
            edge_cnt <= '0;
         end else if (rise) begin
            edge_cnt <= edge_cnt + 1'b1;
         end
      end
   end

endmodule

// File: rtl/pll_subsys_top.sv
`timescale 1ns/100ps
`include "pll_defines.svh"

module pll_subsys_top import wb_pkg::*, pll_pkg::*; (
   input  logic                 clk,        // reference clock
   input  logic                 rst_n,
   input  wb_req_t              wb_req,     // register bus
   output wb_rsp_t              wb_rsp,
   output logic [`PLL_NOUT-1:0] clkout,     // pll outputs
   output logic                 freqlock
);

   pll_cfg_t             cfg;          // divider settings
   pll_ctrl_t            ctrl;         // software controls
   logic                 cfg_change;
   pll_status_t          status;
   logic [`FM_CNTW-1:0]  freq_count;
   logic                 freq_valid;
   logic                 pll_reset;
   logic                 en;
   logic [`PLL_NOUT-1:0] seq_clken;    // clken after sequencer gate
   logic                 phaselock;

   pll_wb_regs i_pll_wb_regs (
      .clk        (clk),
      .rst_n      (rst_n),
      .wb_req     (wb_req),
      .wb_rsp     (wb_rsp),
      .cfg        (cfg),
      .ctrl       (ctrl),
      .cfg_change (cfg_change),
      .status     (status),
      .freq_count (freq_count),
      .freq_valid (freq_valid)
   );

   pll_sequencer i_pll_sequencer (
      .clk        (clk),
      .rst_n      (rst_n),
      .ctrl       (ctrl),
      .cfg_change (cfg_change),
      .freqlock   (freqlock),
      .phaselock  (phaselock),
      .pll_reset  (pll_reset),
      .en         (en),
      .clken      (seq_clken),
      .status     (status)
   );

   pll_model i_pll_model (
      .clk        (clk),          // clkin tied to ref
      .pll_reset  (pll_reset),
      .en         (en),
      .bypass     (ctrl.bypass),
      .clken      (seq_clken),
      .cfg        (cfg),
      .clkout     (clkout),
      .clkvco     (),             // no vco consumer here
      .freqlock   (freqlock),
      .phaselock  (phaselock)
   );

   freq_meter i_freq_meter (
      .clk        (clk),
      .rst_n      (rst_n),
      .clkout     (clkout),
      .sel        (ctrl.meter_sel),
      .count      (freq_count),
      .valid      (freq_valid)
   );

endmodule

// File: dv/tb_pll_subsys.sv
`timescale 1ns/100ps
`include "pll_defines.svh"

module tb_pll_subsys import wb_pkg::*, pll_pkg::*;;

   localparam int TIMEOUT_CYCLES = 20000;   // tests need about 6.5k cycles
   localparam int MEAS_CYCLES    = 600;     // edge count window
   localparam int LOCK_LIMIT     = `PLL_RST_CYCLES + `PLL_LOCK_CYCLES + 4;

   logic                 clk = 1'b0;
   logic                 rst_n;
   wb_req_t              wb_req;
   wb_rsp_t              wb_rsp;
   logic [`PLL_NOUT-1:0] clkout;
   logic                 freqlock;
   int                   errors = 0;
   int                   checks = 0;
   int                   cycles = 0;
   int unsigned          edge_total [`PLL_NOUT];   // free running per output
   int unsigned          edges_seen [`PLL_NOUT];   // last measure_edges result

   always #2 clk = ~clk;   // 4 ns reference

   pll_subsys_top i_pll_subsys_top (
      .clk      (clk),
      .rst_n    (rst_n),
      .wb_req   (wb_req),
      .wb_rsp   (wb_rsp),
      .clkout   (clkout),
      .freqlock (freqlock)
   );

   for (genvar i = 0; i < `PLL_NOUT; i++) begin : g_edges
      int unsigned n = 0;
      always @(posedge clkout[i]) n <= n + 1;
      assign edge_total[i] = n;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("run exceeded %0d cycles, a test is stuck", TIMEOUT_CYCLES);
         $display("checks %0d, errors %0d", checks, errors + 1);
         $display("Finished with errors");
         $finish;
      end
   end

   //##########################################################################
   // helpers
   //##########################################################################

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp, input int tol);
      int diff;
      diff = int'(got) - int'(exp);
      checks++;
      if (diff > tol || diff < -tol) begin
         errors++;
         $display("** Error: %s got 0x%0h expected 0x%0h (tol %0d) at %0t",
                  name, got, exp, tol, $time);
      end
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk);
      #1;   // back to drive point
   endtask

   // one classic transfer entered and left 1 ns after an edge
   task automatic bus_cycle(input logic we, input logic [3:0] adr,
                            input logic [31:0] wdat, output logic [31:0] rdat);
      int wait_cyc;
      wait_cyc = 0;
      wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat, sel: 4'hf};
      #1;
      check_val("ack before edge", 32'(wb_rsp.ack), 32'd0, 0);   // no same cycle ack
      do begin
         wait_cycles(1);
         wait_cyc++;
      end while (!wb_rsp.ack && wait_cyc < 8);
      if (!wb_rsp.ack) begin
         errors++;
         $display("no ack for access to address %0d", adr);
      end
      check_val("ack latency", 32'(wait_cyc), 32'd1, 0);
      rdat   = wb_rsp.dat;   // valid with ack
      wb_req = '0;
      wait_cycles(1);
      check_val("ack after transfer", 32'(wb_rsp.ack), 32'd0, 0);   // single pulse
   endtask

   task automatic wb_write(input logic [3:0] adr, input logic [31:0] wdat);
      logic [31:0] unused;
      bus_cycle(1'b1, adr, wdat, unused);
   endtask

   task automatic wb_read(input logic [3:0] adr, output logic [31:0] rdat);
      bus_cycle(1'b0, adr, 32'h0, rdat);
   endtask

   // CTRL layout from start in bit 0 up to meter_sel in bit 4
   function automatic logic [31:0] ctrl_word(input logic start, input logic bypass,
                                             input logic [1:0] clken, input logic msel);
      return {27'b0, msel, clken, bypass, start};
   endfunction

   function automatic logic [31:0] status_word(input seq_state_e s, input logic fl,
                                               input logic pl, input logic ft);
      pll_status_t st;
      st = '{state: s, freqlock: fl, phaselock: pl, fault: ft};
      return 32'(st);
   endfunction

   task automatic measure_edges(input int n);
      int unsigned start [`PLL_NOUT];
      start = edge_total;
      wait_cycles(n);
      for (int i = 0; i < `PLL_NOUT; i++)
         edges_seen[i] = edge_total[i] - start[i];
   endtask

   task automatic wait_state(input seq_state_e want);
      logic [31:0] rd;
      pll_status_t st;
      int          polls;
      polls = 0;
      do begin
         wb_read(STATUS, rd);
         st = pll_status_t'(rd[$bits(pll_status_t)-1:0]);
         polls++;
      end while (st.state != want && polls < 100);
      if (st.state != want) begin
         errors++;
         $display("STATUS never reached state %s", want.name());
      end
   endtask

   task automatic check_freq(input int divout);
      logic [31:0] rd;
      wait_cycles(2 * `FM_WINDOW + 8);   // one full window on steady clocks
      wb_read(FREQ, rd);
      check_val("FREQ count", 32'(rd[`FM_CNTW-1:0]), `FM_WINDOW / divout, 1);
      check_val("FREQ valid", 32'(rd[16]), 32'd1, 0);
   endtask

   //##########################################################################
   // directed tests
   //##########################################################################

   task automatic test_regs();
      logic [31:0] rd;
      wb_write(DIV, 32'hab12_3456);   // top byte reserved
      wb_write(OUT, 32'h0000_0604);   // out1 /6, out0 /4
      wb_read(DIV, rd);
      check_val("DIV", rd, 32'h0012_3456, 0);
      wb_read(OUT, rd);
      check_val("OUT", rd, 32'h0000_0604, 0);
      wb_write(4'd9, 32'hffff_ffff);
      wb_read(4'd9, rd);
      check_val("unmapped read", rd, 32'h0, 0);
   endtask

   task automatic test_power_up();
      logic [31:0] rd;
      int unsigned start [`PLL_NOUT];
      int          n;
      start = edge_total;
      wb_write(CTRL, ctrl_word(1'b1, 1'b0, 2'b11, 1'b0));
      n = 0;
      while (!freqlock && n < LOCK_LIMIT) begin
         wait_cycles(1);
         n++;
      end
      if (!freqlock) begin
         errors++;
         $display("freqlock did not rise within %0d cycles of start", LOCK_LIMIT);
      end
      for (int i = 0; i < `PLL_NOUT; i++)
         check_val("clkout edges before RUN", edge_total[i] - start[i], 32'd0, 0);
      wait_state(RUN);
      wb_read(STATUS, rd);
      check_val("STATUS", rd, status_word(RUN, 1'b1, 1'b1, 1'b0), 0);
   endtask

   task automatic test_divider();
      measure_edges(MEAS_CYCLES);
      check_val("clkout[0] edges", edges_seen[0], MEAS_CYCLES / 4, 1);
      check_val("clkout[1] edges", edges_seen[1], MEAS_CYCLES / 6, 1);
      check_freq(4);   // meter_sel already 0
      wb_write(CTRL, ctrl_word(1'b1, 1'b0, 2'b11, 1'b1));
      check_freq(6);
   endtask

   task automatic test_reconfig();
      logic [31:0] rd;
      wb_write(OUT, 32'h0000_0802);   // out1 /8, out0 /2
      measure_edges(2);
      wb_read(STATUS, rd);
      check_val("STATUS after OUT write", rd, status_word(RST, 1'b0, 1'b0, 1'b0), 0);
      for (int i = 0; i < `PLL_NOUT; i++)
         check_val("clkout edges in relock", edges_seen[i], 32'd0, 0);
      wait_state(RUN);
      measure_edges(MEAS_CYCLES);
      check_val("clkout[0] edges", edges_seen[0], MEAS_CYCLES / 2, 1);
      check_val("clkout[1] edges", edges_seen[1], MEAS_CYCLES / 8, 1);
   endtask

   task automatic test_bypass();
      wb_write(CTRL, 32'h0);
      wb_write(CTRL, ctrl_word(1'b1, 1'b1, 2'b11, 1'b0));
      wait_state(RUN);
      measure_edges(MEAS_CYCLES);
      check_val("clkout[0] bypass edges", edges_seen[0], MEAS_CYCLES, 1);
      check_val("clkout[1] bypass edges", edges_seen[1], MEAS_CYCLES, 1);
   endtask

   task automatic test_stop();
      logic [31:0] rd;
      wb_write(CTRL, 32'h0);
      wait_cycles(2);
      wb_read(STATUS, rd);
      check_val("STATUS after stop", rd, status_word(OFF, 1'b0, 1'b0, 1'b0), 0);
      measure_edges(100);
      check_val("clkout[0] edges when off", edges_seen[0], 32'd0, 0);
      check_val("clkout[1] edges when off", edges_seen[1], 32'd0, 0);
   endtask

   initial begin
      rst_n  = 1'b0;
      wb_req = '0;
      repeat (10) @(posedge clk);
      #1;
      check_val("ack in reset", 32'(wb_rsp.ack), 32'd0, 0);
      check_val("clkout in reset", 32'(clkout), 32'd0, 0);
      rst_n = 1'b1;
      wait_cycles(2);
      test_regs();
      test_power_up();
      test_divider();
      test_reconfig();
      test_bypass();
      test_stop();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// File: filelist.f
+incdir+rtl
rtl/wb_pkg.sv
rtl/pll_pkg.sv
rtl/pll_model.sv
rtl/pll_wb_regs.sv
rtl/pll_sequencer.sv
rtl/freq_meter.sv
rtl/pll_subsys_top.sv
dv/tb_pll_subsys.sv

// File: run_sim.sh
#!/bin/sh
# build and run the PLL subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module tb_pll_subsys -f filelist.f -o tb_sim \
   && ./obj_dir/tb_sim | tee sim.log \
   && grep -qx "Finished with no errors" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
